/* design/alu_op_pkg.sv */
`default_nettype none

package alu_op_pkg;

   typedef logic [2:0] alu_mode_t;

   localparam alu_mode_t ALU_ADD = 3'd0;
   localparam alu_mode_t ALU_SUB = 3'd1;
   localparam alu_mode_t ALU_AND = 3'd2;
   localparam alu_mode_t ALU_OR  = 3'd3;
   localparam alu_mode_t ALU_XOR = 3'd4;
   // shift amount from b[3:0]
   localparam alu_mode_t ALU_SLL = 3'd5;
   localparam alu_mode_t ALU_SRL = 3'd6;
   // load immediate, result is b
   localparam alu_mode_t ALU_LDI = 3'd7;

endpackage

`default_nettype wire

/* design/alu_unit.sv */
`default_nettype none

module alu_unit (
   input  logic          clk,
   input  logic          rst,
   input  logic          stall,
   ex_op_if.consumer     ex,
   wb_port_if.producer   wb
);

   backend_types_pkg::data_t  result;
   logic [3:0]                shamt;

   assign shamt = ex.b[3:0];

   always_comb begin
      case (ex.mode)
         alu_op_pkg::ALU_ADD: result = ex.a + ex.b;
         alu_op_pkg::ALU_SUB: result = ex.a - ex.b;
         alu_op_pkg::ALU_AND: result = ex.a & ex.b;
         alu_op_pkg::ALU_OR:  result = ex.a | ex.b;
         alu_op_pkg::ALU_XOR: result = ex.a ^ ex.b;
         alu_op_pkg::ALU_SLL: result = ex.a << shamt;
         alu_op_pkg::ALU_SRL: result = ex.a >> shamt;
         default:             result = ex.b;
      endcase
   end

   // ex to wb register
   always_ff @(posedge clk) begin
      if (rst) begin
         wb.done <= 1'b0;
         wb.wrt  <= 1'b0;
      end else if (!stall) begin
         wb.done <= ex.vld;
         wb.wrt  <= ex.vld & ex.reg_wrt;
      end
   end

   always_ff @(posedge clk) begin
      if (!stall) begin
         wb.dst  <= ex.dst;
         wb.data <= result;
         wb.idx  <= ex.idx;
      end
   end

endmodule

`default_nettype wire

/* design/backend_ifs.sv */
`default_nettype none

// issued packet for one lane
interface issue_lane_if;
   logic                         vld;
   alu_op_pkg::alu_mode_t        mode;
   backend_types_pkg::preg_t     src1;
   backend_types_pkg::preg_t     src2;
   backend_types_pkg::preg_t     dst;
   backend_types_pkg::data_t     imm;
   logic                         imm_vld;
   logic                         reg_wrt;
   backend_types_pkg::rob_idx_t  idx;

   modport source (output vld, mode, src1, src2, dst, imm, imm_vld, reg_wrt, idx);
   modport sink   (input  vld, mode, src1, src2, dst, imm, imm_vld, reg_wrt, idx);
endinterface

// two read ports of the register file
interface rf_read_if;
   backend_types_pkg::preg_t  addr1;
   backend_types_pkg::preg_t  addr2;
   backend_types_pkg::data_t  data1;
   backend_types_pkg::data_t  data2;

   modport requester (output addr1, addr2, input  data1, data2);
   modport responder (input  addr1, addr2, output data1, data2);
endinterface

// operands into an execute unit
interface ex_op_if;
   logic                         vld;
   alu_op_pkg::alu_mode_t        mode;
   backend_types_pkg::data_t     a;
   backend_types_pkg::data_t     b;
   backend_types_pkg::preg_t     dst;
   logic                         reg_wrt;
   backend_types_pkg::rob_idx_t  idx;

   modport producer (output vld, mode, a, b, dst, reg_wrt, idx);
   modport consumer (input  vld, mode, a, b, dst, reg_wrt, idx);
endinterface

// writeback and completion of one lane
interface wb_port_if;
   logic                         done;
   logic                         wrt;
   backend_types_pkg::preg_t     dst;
   backend_types_pkg::data_t     data;
   backend_types_pkg::rob_idx_t  idx;

   modport producer (output done, wrt, dst, data, idx);
   modport consumer (input  done, wrt, dst, data, idx);
endinterface

`default_nettype wire

/* design/backend_types_pkg.sv */
`default_nettype none

package backend_types_pkg;

   // datapath width
   localparam int DATA_W = 16;

   // physical register space
   localparam int PREG_W    = 6;
   localparam int NUM_PREGS = 64;

   // reorder buffer index width
   localparam int ROB_IDX_W = 6;

   // operand and result values
   typedef logic [DATA_W-1:0] data_t;

   // physical register number
   typedef logic [PREG_W-1:0] preg_t;

   // rob entry of an instruction
   typedef logic [ROB_IDX_W-1:0] rob_idx_t;

endpackage

`default_nettype wire

/* design/exec_backend.sv */
`default_nettype none

module exec_backend #(
   parameter int MULT_LAT = 3
) (
   input  logic                         clk,
   input  logic                         rst,
   input  logic                         stall,
   // alu lane 1
   input  logic                         alu1_vld,
   input  alu_op_pkg::alu_mode_t        alu1_mode,
   input  backend_types_pkg::preg_t     alu1_src1,
   input  backend_types_pkg::preg_t     alu1_src2,
   input  backend_types_pkg::preg_t     alu1_dst,
   input  backend_types_pkg::data_t     alu1_imm,
   input  logic                         alu1_imm_vld,
   input  logic                         alu1_reg_wrt,
   input  backend_types_pkg::rob_idx_t  alu1_idx,
   output logic                         alu1_done,
   output logic                         alu1_wrt,
   output backend_types_pkg::preg_t     alu1_wb_dst,
   output backend_types_pkg::data_t     alu1_wb_data,
   output backend_types_pkg::rob_idx_t  alu1_wb_idx,
   // alu lane 2
   input  logic                         alu2_vld,
   input  alu_op_pkg::alu_mode_t        alu2_mode,
   input  backend_types_pkg::preg_t     alu2_src1,
   input  backend_types_pkg::preg_t     alu2_src2,
   input  backend_types_pkg::preg_t     alu2_dst,
   input  backend_types_pkg::data_t     alu2_imm,
   input  logic                         alu2_imm_vld,
   input  logic                         alu2_reg_wrt,
   input  backend_types_pkg::rob_idx_t  alu2_idx,
   output logic                         alu2_done,
   output logic                         alu2_wrt,
   output backend_types_pkg::preg_t     alu2_wb_dst,
   output backend_types_pkg::data_t     alu2_wb_data,
   output backend_types_pkg::rob_idx_t  alu2_wb_idx,
   // multiplier lane
   input  logic                         mult_vld,
   input  backend_types_pkg::preg_t     mult_src1,
   input  backend_types_pkg::preg_t     mult_src2,
   input  backend_types_pkg::preg_t     mult_dst,
   input  backend_types_pkg::data_t     mult_imm,
   input  logic                         mult_imm_vld,
   input  logic                         mult_reg_wrt,
   input  backend_types_pkg::rob_idx_t  mult_idx,
   output logic                         mult_done,
   output logic                         mult_wrt,
   output backend_types_pkg::preg_t     mult_wb_dst,
   output backend_types_pkg::data_t     mult_wb_data,
   output backend_types_pkg::rob_idx_t  mult_wb_idx
);

   // lane 0 is alu1, lane 1 is alu2, lane 2 is the multiplier
   issue_lane_if  iss_if [3] ();
   rf_read_if     rd_if  [3] ();
   ex_op_if       ex_if  [3] ();
   wb_port_if     wb_if  [3] ();

   assign iss_if[0].vld     = alu1_vld;
   assign iss_if[0].mode    = alu1_mode;
   assign iss_if[0].src1    = alu1_src1;
   assign iss_if[0].src2    = alu1_src2;
   assign iss_if[0].dst     = alu1_dst;
   assign iss_if[0].imm     = alu1_imm;
   assign iss_if[0].imm_vld = alu1_imm_vld;
   assign iss_if[0].reg_wrt = alu1_reg_wrt;
   assign iss_if[0].idx     = alu1_idx;

   assign iss_if[1].vld     = alu2_vld;
   assign iss_if[1].mode    = alu2_mode;
   assign iss_if[1].src1    = alu2_src1;
   assign iss_if[1].src2    = alu2_src2;
   assign iss_if[1].dst     = alu2_dst;
   assign iss_if[1].imm     = alu2_imm;
   assign iss_if[1].imm_vld = alu2_imm_vld;
   assign iss_if[1].reg_wrt = alu2_reg_wrt;
   assign iss_if[1].idx     = alu2_idx;

   assign iss_if[2].vld     = mult_vld;
   // no mode on the multiplier lane
   assign iss_if[2].mode    = '0;
   assign iss_if[2].src1    = mult_src1;
   assign iss_if[2].src2    = mult_src2;
   assign iss_if[2].dst     = mult_dst;
   assign iss_if[2].imm     = mult_imm;
   assign iss_if[2].imm_vld = mult_imm_vld;
   assign iss_if[2].reg_wrt = mult_reg_wrt;
   assign iss_if[2].idx     = mult_idx;

   preg_file u_preg_file (
      .clk (clk),
      .rst (rst),
      .rd  (rd_if),
      .wr  (wb_if)
   );

   for (genvar i = 0; i < 3; i++) begin : g_fetch
      operand_fetch u_fetch (
         .clk   (clk),
         .rst   (rst),
         .stall (stall),
         .iss   (iss_if[i]),
         .rd    (rd_if[i]),
         .ex    (ex_if[i])
      );
   end

   for (genvar i = 0; i < 2; i++) begin : g_alu
      alu_unit u_alu (
         .clk   (clk),
         .rst   (rst),
         .stall (stall),
         .ex    (ex_if[i]),
         .wb    (wb_if[i])
      );
   end

   mult_unit #(
      .MULT_LAT (MULT_LAT)
   ) u_mult (
      .clk   (clk),
      .rst   (rst),
      .stall (stall),
      .ex    (ex_if[2]),
      .wb    (wb_if[2])
   );

   assign alu1_done    = wb_if[0].done;
   assign alu1_wrt     = wb_if[0].wrt;
   assign alu1_wb_dst  = wb_if[0].dst;
   assign alu1_wb_data = wb_if[0].data;
   assign alu1_wb_idx  = wb_if[0].idx;

   assign alu2_done    = wb_if[1].done;
   assign alu2_wrt     = wb_if[1].wrt;
   assign alu2_wb_dst  = wb_if[1].dst;
   assign alu2_wb_data = wb_if[1].data;
   assign alu2_wb_idx  = wb_if[1].idx;

   assign mult_done    = wb_if[2].done;
   assign mult_wrt     = wb_if[2].wrt;
   assign mult_wb_dst  = wb_if[2].dst;
   assign mult_wb_data = wb_if[2].data;
   assign mult_wb_idx  = wb_if[2].idx;

endmodule

`default_nettype wire

/* design/mult_unit.sv */
`default_nettype none

module mult_unit #(
   parameter int MULT_LAT = 3
) (
   input  logic          clk,
   input  logic          rst,
   input  logic          stall,
   ex_op_if.consumer     ex,
   wb_port_if.producer   wb
);

   backend_types_pkg::data_t  prod;

   logic                         vld_q  [MULT_LAT];
   logic                         wrt_q  [MULT_LAT];
   backend_types_pkg::preg_t     dst_q  [MULT_LAT];
   backend_types_pkg::data_t     data_q [MULT_LAT];
   backend_types_pkg::rob_idx_t  idx_q  [MULT_LAT];

   // only the low half of the product is kept
   assign prod = ex.a * ex.b;

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < MULT_LAT; i++) begin
            vld_q[i] <= 1'b0;
            wrt_q[i] <= 1'b0;
         end
      end else if (!stall) begin
         vld_q[0] <= ex.vld;
         wrt_q[0] <= ex.vld & ex.reg_wrt;
         for (int i = 1; i < MULT_LAT; i++) begin
            vld_q[i] <= vld_q[i-1];
            wrt_q[i] <= wrt_q[i-1];
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!stall) begin
         dst_q[0]  <= ex.dst;
         data_q[0] <= prod;
         idx_q[0]  <= ex.idx;
         for (int i = 1; i < MULT_LAT; i++) begin
            dst_q[i]  <= dst_q[i-1];
            data_q[i] <= data_q[i-1];
            idx_q[i]  <= idx_q[i-1];
         end
      end
   end

   // last stage is the writeback register
   assign wb.done = vld_q[MULT_LAT-1];
   assign wb.wrt  = wrt_q[MULT_LAT-1];
   assign wb.dst  = dst_q[MULT_LAT-1];
   assign wb.data = data_q[MULT_LAT-1];
   assign wb.idx  = idx_q[MULT_LAT-1];

endmodule

`default_nettype wire

/* design/operand_fetch.sv */
`default_nettype none

module operand_fetch (
   input  logic          clk,
   input  logic          rst,
   input  logic          stall,
   issue_lane_if.sink    iss,
   rf_read_if.requester  rd,
   ex_op_if.producer     ex
);

   // issue to rf register
   logic                         s1_vld;
   alu_op_pkg::alu_mode_t        s1_mode;
   backend_types_pkg::preg_t     s1_src1;
   backend_types_pkg::preg_t     s1_src2;
   backend_types_pkg::preg_t     s1_dst;
   backend_types_pkg::data_t     s1_imm;
   logic                         s1_imm_vld;
   logic                         s1_reg_wrt;
   backend_types_pkg::rob_idx_t  s1_idx;

   assign rd.addr1 = s1_src1;
   assign rd.addr2 = s1_src2;

   always_ff @(posedge clk) begin
      if (rst) begin
         s1_vld <= 1'b0;
         ex.vld <= 1'b0;
      end else if (!stall) begin
         s1_vld <= iss.vld;
         ex.vld <= s1_vld;
      end
   end

   always_ff @(posedge clk) begin
      if (!stall) begin
         s1_mode    <= iss.mode;
         s1_src1    <= iss.src1;
         s1_src2    <= iss.src2;
         s1_dst     <= iss.dst;
         s1_imm     <= iss.imm;
         s1_imm_vld <= iss.imm_vld;
         s1_reg_wrt <= iss.reg_wrt;
         s1_idx     <= iss.idx;
      end
   end

   // rf to ex register
   always_ff @(posedge clk) begin
      if (!stall) begin
         ex.mode    <= s1_mode;
         ex.a       <= rd.data1;
         // immediate replaces the second register operand
         ex.b       <= s1_imm_vld ? s1_imm : rd.data2;
         ex.dst     <= s1_dst;
         ex.reg_wrt <= s1_reg_wrt;
         ex.idx     <= s1_idx;
      end
   end

endmodule

`default_nettype wire

/* design/preg_file.sv */
`default_nettype none

module preg_file (
   input  logic          clk,
   input  logic          rst,
   rf_read_if.responder  rd [3],
   wb_port_if.consumer   wr [3]
);

   localparam int PORTS = 3;

   backend_types_pkg::data_t  regs [backend_types_pkg::NUM_PREGS];

   logic                      wr_en   [PORTS];
   backend_types_pkg::preg_t  wr_dst  [PORTS];
   backend_types_pkg::data_t  wr_data [PORTS];

   backend_types_pkg::preg_t  rd_addr1 [PORTS];
   backend_types_pkg::preg_t  rd_addr2 [PORTS];
   backend_types_pkg::data_t  rd_data1 [PORTS];
   backend_types_pkg::data_t  rd_data2 [PORTS];

   for (genvar g = 0; g < PORTS; g++) begin : g_port
      assign wr_en[g]   = wr[g].done & wr[g].wrt;
      assign wr_dst[g]  = wr[g].dst;
      assign wr_data[g] = wr[g].data;

      assign rd_addr1[g] = rd[g].addr1;
      assign rd_addr2[g] = rd[g].addr2;

      // write-first, a later port wins as in the write loop
      always_comb begin
         rd_data1[g] = regs[rd_addr1[g]];
         rd_data2[g] = regs[rd_addr2[g]];
         for (int p = 0; p < PORTS; p++) begin
            if (wr_en[p] && wr_dst[p] == rd_addr1[g]) rd_data1[g] = wr_data[p];
            if (wr_en[p] && wr_dst[p] == rd_addr2[g]) rd_data2[g] = wr_data[p];
         end
      end

      assign rd[g].data1 = rd_data1[g];
      assign rd[g].data2 = rd_data2[g];
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int r = 0; r < backend_types_pkg::NUM_PREGS; r++) begin
            regs[r] <= '0;
         end
      end else begin
         for (int p = 0; p < PORTS; p++) begin
            if (wr_en[p]) regs[wr_dst[p]] <= wr_data[p];
         end
      end
   end

endmodule

`default_nettype wire

/* flist.f */
design/backend_types_pkg.sv
design/alu_op_pkg.sv
design/backend_ifs.sv
design/preg_file.sv
design/operand_fetch.sv
design/alu_unit.sv
design/mult_unit.sv
design/exec_backend.sv
test/tb_exec_backend.sv

/* run_sim.sh */
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output
verilator --binary --timing --timescale 1ns/1ps -f flist.f \
   --top-module tb_exec_backend -o sim_exec_backend \
   && ./obj_dir/sim_exec_backend | tee /dev/stderr | grep -qF '*** TEST PASSED ***' \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }

/* test/tb_exec_backend.sv */
`default_nettype none

module tb_exec_backend;
   timeunit 1ns;
   timeprecision 1ps;

   typedef backend_types_pkg::data_t    data_t;
   typedef backend_types_pkg::preg_t    preg_t;
   typedef backend_types_pkg::rob_idx_t rob_idx_t;
   typedef alu_op_pkg::alu_mode_t       mode_t;

   localparam int MULT_LAT = 3;
   localparam int NREGS    = backend_types_pkg::NUM_PREGS;

   // one expected completion
   typedef struct packed {
      data_t    data;
      preg_t    dst;
      rob_idx_t idx;
      logic     wrt;
      int       due;
   } exp_t;

   logic clk = 1'b0;
   logic rst;
   logic stall;

   // lane 0 is alu1, lane 1 is alu2, lane 2 is the multiplier
   logic     in_vld     [3];
   mode_t    in_mode    [3];
   preg_t    in_src1    [3];
   preg_t    in_src2    [3];
   preg_t    in_dst     [3];
   data_t    in_imm     [3];
   logic     in_imm_vld [3];
   logic     in_reg_wrt [3];
   rob_idx_t in_idx     [3];

   logic     done_o  [3];
   logic     wrt_o   [3];
   preg_t    dst_o   [3];
   data_t    data_o  [3];
   rob_idx_t idx_o   [3];

   exp_t     exp_q [3][$];
   data_t    model_reg  [NREGS];
   // a register is ready when all of its issued writes have been seen
   int       issued_cnt [NREGS];
   int       done_cnt   [NREGS];
   int       iss_lane_cnt [3];
   int       cmp_lane_cnt [3];
   rob_idx_t next_idx [3];
   // unstalled edges seen so far
   int       ucnt;
   int       checks;
   int       errors;
   int       timeouts;
   logic [31:0] lcg_state = 32'h054d3b5f;

   always #4 clk = ~clk;

   exec_backend #(
      .MULT_LAT (MULT_LAT)
   ) dut (
      .clk          (clk),
      .rst          (rst),
      .stall        (stall),
      .alu1_vld     (in_vld[0]),
      .alu1_mode    (in_mode[0]),
      .alu1_src1    (in_src1[0]),
      .alu1_src2    (in_src2[0]),
      .alu1_dst     (in_dst[0]),
      .alu1_imm     (in_imm[0]),
      .alu1_imm_vld (in_imm_vld[0]),
      .alu1_reg_wrt (in_reg_wrt[0]),
      .alu1_idx     (in_idx[0]),
      .alu1_done    (done_o[0]),
      .alu1_wrt     (wrt_o[0]),
      .alu1_wb_dst  (dst_o[0]),
      .alu1_wb_data (data_o[0]),
      .alu1_wb_idx  (idx_o[0]),
      .alu2_vld     (in_vld[1]),
      .alu2_mode    (in_mode[1]),
      .alu2_src1    (in_src1[1]),
      .alu2_src2    (in_src2[1]),
      .alu2_dst     (in_dst[1]),
      .alu2_imm     (in_imm[1]),
      .alu2_imm_vld (in_imm_vld[1]),
      .alu2_reg_wrt (in_reg_wrt[1]),
      .alu2_idx     (in_idx[1]),
      .alu2_done    (done_o[1]),
      .alu2_wrt     (wrt_o[1]),
      .alu2_wb_dst  (dst_o[1]),
      .alu2_wb_data (data_o[1]),
      .alu2_wb_idx  (idx_o[1]),
      .mult_vld     (in_vld[2]),
      .mult_src1    (in_src1[2]),
      .mult_src2    (in_src2[2]),
      .mult_dst     (in_dst[2]),
      .mult_imm     (in_imm[2]),
      .mult_imm_vld (in_imm_vld[2]),
      .mult_reg_wrt (in_reg_wrt[2]),
      .mult_idx     (in_idx[2]),
      .mult_done    (done_o[2]),
      .mult_wrt     (wrt_o[2]),
      .mult_wb_dst  (dst_o[2]),
      .mult_wb_data (data_o[2]),
      .mult_wb_idx  (idx_o[2])
   );

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic int rand_below(input int n);
      logic [31:0] r;
      r = lcg_next();
      return int'(r[30:8]) % n;
   endfunction

   // expected result of one operation
   function automatic data_t ref_result(input logic is_mul, input mode_t mode,
                                        input data_t a, input data_t b);
      logic [31:0] full;
      full = 32'(a) * 32'(b);
      if (is_mul) begin
         return full[15:0];
      end
      case (mode)
         alu_op_pkg::ALU_ADD: return a + b;
         alu_op_pkg::ALU_SUB: return a - b;
         alu_op_pkg::ALU_AND: return a & b;
         alu_op_pkg::ALU_OR:  return a | b;
         alu_op_pkg::ALU_XOR: return a ^ b;
         alu_op_pkg::ALU_SLL: return a << b[3:0];
         alu_op_pkg::ALU_SRL: return a >> b[3:0];
         default:             return b;
      endcase
   endfunction

   function automatic int lane_lat(input int l);
      return (l == 2) ? 2 + MULT_LAT : 3;
   endfunction

   function automatic string lane_name(input int l);
      case (l)
         0:       return "alu1";
         1:       return "alu2";
         default: return "mult";
      endcase
   endfunction

   function automatic logic reg_ready(input preg_t r);
      return issued_cnt[r] == done_cnt[r];
   endfunction

   function automatic preg_t pick_ready();
      int start;
      preg_t r;
      start = rand_below(NREGS);
      for (int k = 0; k < NREGS; k++) begin
         r = preg_t'((start + k) % NREGS);
         if (reg_ready(r)) begin
            return r;
         end
      end
      return preg_t'(start);
   endfunction

   task automatic check_data(input string what, input data_t got, input data_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[ERROR] %0d ns: %s data %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_preg(input string what, input preg_t got, input preg_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[ERROR] %0d ns: %s dst %0d, expected %0d", $time, what, got, exp);
      end
   endtask

   task automatic check_idx(input string what, input rob_idx_t got, input rob_idx_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[ERROR] %0d ns: %s rob index %0d, expected %0d", $time, what, got, exp);
      end
   endtask

   task automatic check_flag(input string what, input logic got, input logic exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[ERROR] %0d ns: %s wrt %b, expected %b", $time, what, got, exp);
      end
   endtask

   task automatic check_cycle(input string what, input int got, input int exp);
      checks++;
      if (got != exp) begin
         errors++;
         $display("[ERROR] %0d ns: %s done at edge %0d, expected %0d", $time, what, got, exp);
      end
   endtask

   // compares completions and records accepted issues
   always @(posedge clk) begin
      exp_t  e;
      data_t a;
      data_t b;
      if (rst) begin
         ucnt <= 0;
         for (int r = 0; r < NREGS; r++) begin
            model_reg[r] <= '0;
            done_cnt[r]  <= 0;
         end
      end else if (!stall) begin
         ucnt <= ucnt + 1;
         for (int l = 0; l < 3; l++) begin
            if (done_o[l]) begin
               if (exp_q[l].size() == 0) begin
                  errors++;
                  $display("[ERROR] %0d ns: %s completed with nothing outstanding",
                           $time, lane_name(l));
               end else begin
                  e = exp_q[l].pop_front();
                  check_flag(lane_name(l), wrt_o[l], e.wrt);
                  check_preg(lane_name(l), dst_o[l], e.dst);
                  check_data(lane_name(l), data_o[l], e.data);
                  check_idx(lane_name(l), idx_o[l], e.idx);
                  check_cycle(lane_name(l), ucnt, e.due);
                  if (e.wrt) begin
                     model_reg[e.dst] <= e.data;
                     done_cnt[e.dst]  <= done_cnt[e.dst] + 1;
                  end
                  cmp_lane_cnt[l] <= cmp_lane_cnt[l] + 1;
               end
            end
            if (in_vld[l]) begin
               a = model_reg[in_src1[l]];
               b = in_imm_vld[l] ? in_imm[l] : model_reg[in_src2[l]];
               e.data = ref_result(l == 2, in_mode[l], a, b);
               e.dst  = in_dst[l];
               e.idx  = in_idx[l];
               e.wrt  = in_reg_wrt[l];
               e.due  = ucnt + lane_lat(l);
               exp_q[l].push_back(e);
            end
         end
      end
   end

   task drive_lane(input int l, input logic accept, input logic vld, input mode_t mode,
                   input preg_t s1, input preg_t s2, input preg_t d, input data_t imm,
                   input logic imm_vld, input logic wrt);
      in_vld[l]     <= vld;
      in_mode[l]    <= mode;
      in_src1[l]    <= s1;
      in_src2[l]    <= s2;
      in_dst[l]     <= d;
      in_imm[l]     <= imm;
      in_imm_vld[l] <= imm_vld;
      in_reg_wrt[l] <= wrt;
      in_idx[l]     <= next_idx[l];
      if (accept) begin
         next_idx[l]     = next_idx[l] + 1'b1;
         iss_lane_cnt[l] = iss_lane_cnt[l] + 1;
         if (wrt) begin
            issued_cnt[d] = issued_cnt[d] + 1;
         end
      end
   endtask

   task idle_lanes();
      stall <= 1'b0;
      for (int l = 0; l < 3; l++) begin
         in_vld[l] <= 1'b0;
      end
   endtask

   // junk with a random valid while the next edge is stalled
   task issue_random(input int l, input logic accept);
      mode_t mode;
      preg_t s1;
      preg_t s2;
      preg_t d;
      logic [31:0] r;
      mode = (l == 2) ? alu_op_pkg::ALU_ADD : mode_t'(rand_below(8));
      s1 = pick_ready();
      s2 = pick_ready();
      d  = pick_ready();
      r  = lcg_next();
      drive_lane(l, accept, accept || r[0], mode, s1, s2, d, r[23:8],
                 r[26:25] == 2'b00, r[31:29] != 3'b000);
   endtask

   task run_traffic(input int cycles, input int stall_pct, input int issue_pct,
                    input logic [2:0] lanes);
      logic st;
      for (int c = 0; c < cycles; c++) begin
         st = rand_below(100) < stall_pct;
         stall <= st;
         for (int l = 0; l < 3; l++) begin
            if (lanes[l] && rand_below(100) < issue_pct) begin
               issue_random(l, !st);
            end else begin
               in_vld[l] <= 1'b0;
            end
         end
         @(posedge clk);
      end
      idle_lanes();
   endtask

   task wait_drain(input int limit);
      int n;
      logic busy;
      n = 0;
      busy = 1'b1;
      while (busy && n < limit) begin
         @(posedge clk);
         n++;
         busy = 1'b0;
         for (int l = 0; l < 3; l++) begin
            if (cmp_lane_cnt[l] != iss_lane_cnt[l]) begin
               busy = 1'b1;
            end
         end
      end
      if (busy) begin
         timeouts++;
         for (int l = 0; l < 3; l++) begin
            if (cmp_lane_cnt[l] != iss_lane_cnt[l]) begin
               $display("timeout: %s still has %0d completions outstanding after %0d cycles",
                        lane_name(l), iss_lane_cnt[l] - cmp_lane_cnt[l], limit);
            end
         end
      end
   endtask

   initial begin
      rst   <= 1'b1;
      stall <= 1'b0;
      for (int l = 0; l < 3; l++) begin
         in_vld[l]     <= 1'b0;
         in_mode[l]    <= alu_op_pkg::ALU_ADD;
         in_src1[l]    <= '0;
         in_src2[l]    <= '0;
         in_dst[l]     <= '0;
         in_imm[l]     <= '0;
         in_imm_vld[l] <= 1'b0;
         in_reg_wrt[l] <= 1'b0;
         in_idx[l]     <= '0;
         next_idx[l]    = '0;
      end
      repeat (3) @(posedge clk);
      rst <= 1'b0;
      // any done while idle is flagged by the compare process
      repeat (4) @(posedge clk);

      // never written registers read zero
      drive_lane(0, 1'b1, 1'b1, alu_op_pkg::ALU_ADD, 6'd1, 6'd2, 6'd3, 16'h0000, 1'b0, 1'b1);
      @(posedge clk);
      idle_lanes();
      wait_drain(20);

      drive_lane(0, 1'b1, 1'b1, alu_op_pkg::ALU_LDI, 6'd0, 6'd0, 6'd10, 16'h1234, 1'b1, 1'b1);
      drive_lane(1, 1'b1, 1'b1, alu_op_pkg::ALU_LDI, 6'd0, 6'd0, 6'd11, 16'hbeef, 1'b1, 1'b1);
      @(posedge clk);
      idle_lanes();
      wait_drain(20);
      drive_lane(0, 1'b1, 1'b1, alu_op_pkg::ALU_ADD, 6'd10, 6'd11, 6'd12, 16'h0000, 1'b0, 1'b1);
      drive_lane(1, 1'b1, 1'b1, alu_op_pkg::ALU_SUB, 6'd11, 6'd10, 6'd13, 16'h0000, 1'b0, 1'b1);
      @(posedge clk);
      idle_lanes();
      wait_drain(20);

      // completion without a write keeps the old r10
      drive_lane(0, 1'b1, 1'b1, alu_op_pkg::ALU_LDI, 6'd0, 6'd0, 6'd10, 16'h5a5a, 1'b1, 1'b0);
      @(posedge clk);
      idle_lanes();
      wait_drain(20);
      drive_lane(1, 1'b1, 1'b1, alu_op_pkg::ALU_OR, 6'd10, 6'd0, 6'd14, 16'h0000, 1'b1, 1'b1);
      @(posedge clk);
      idle_lanes();
      wait_drain(20);

      run_traffic(300, 0, 80, 3'b011);
      wait_drain(50);
      // back to back multiplies
      run_traffic(40, 0, 100, 3'b100);
      wait_drain(50);
      run_traffic(600, 30, 70, 3'b111);
      wait_drain(100);

      $display("checks %0d  errors %0d  timeouts %0d", checks, errors, timeouts);
      if (errors == 0 && timeouts == 0 && checks > 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire
